// ==== rtl/cam_display_config.svh ====
/* display timing and buffer geometry */
`ifndef CAM_DISPLAY_CONFIG_SVH
`define CAM_DISPLAY_CONFIG_SVH

`define H_ACTIVE 640    // pixel clocks
`define H_FRONT  16
`define H_SYNC   96
`define H_BACK   48
`define H_TOTAL  800

`define V_ACTIVE 480    // lines
`define V_FRONT  10
`define V_SYNC   2
`define V_BACK   33
`define V_TOTAL  525

`define FB_W           320
`define FB_H           240
`define FB_DEPTH       76800
`define FB_BANK0_DEPTH 32768   // first word of bank 1

// read path latencies in clocks
`define MEM_RD_LAT 2
`define PIX_LAT    1
`define SYNC_DELAY (`MEM_RD_LAT + `PIX_LAT)

`endif

// ==== rtl/cam_display_pkg.sv ====
/* display types */
`default_nettype none

package cam_display_pkg;

    typedef logic [16:0] fb_addr_t;   // covers 76800 words

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // hsync and vsync are active low
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic blank_n;
    } vga_sync_t;

    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        rgb565_t  data;
    } fb_write_t;

    // sync high, picture blanked
    localparam vga_sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0};

endpackage

`default_nettype wire

// ==== rtl/vga_timing.sv ====
/* vga 640x480 timing */
`timescale 1ns/1ps
`default_nettype none
`include "cam_display_config.svh"

module vga_timing (
    input  wire logic                  clk_25_vga,
    input  wire logic                  rst_n,
    output cam_display_pkg::vga_sync_t sync,
    output logic                       active,
    output cam_display_pkg::fb_addr_t  rd_addr
);
    import cam_display_pkg::*;

    localparam logic [9:0] H_ACT    = 10'(`H_ACTIVE);
    localparam logic [9:0] H_LAST   = 10'(`H_TOTAL - 1);
    localparam logic [9:0] HS_START = 10'(`H_ACTIVE + `H_FRONT);
    localparam logic [9:0] HS_END   = 10'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam logic [9:0] V_ACT    = 10'(`V_ACTIVE);
    localparam logic [9:0] V_LAST   = 10'(`V_TOTAL - 1);
    localparam logic [9:0] VS_START = 10'(`V_ACTIVE + `V_FRONT);
    localparam logic [9:0] VS_END   = 10'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       line_end;
    logic       hs_n;
    logic       vs_n;
    fb_addr_t   row_base;
    fb_addr_t   col;

    assign line_end = (h_cnt == H_LAST);

    always_ff @(posedge clk_25_vga or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (line_end) begin
                h_cnt <= '0;
                if (v_cnt == V_LAST) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 10'd1;
                end
            end else begin
                h_cnt <= h_cnt + 10'd1;
            end
        end
    end

    assign active = (h_cnt < H_ACT) && (v_cnt < V_ACT);
    assign hs_n   = !((h_cnt >= HS_START) && (h_cnt < HS_END));   // 656..751
    assign vs_n   = !((v_cnt >= VS_START) && (v_cnt < VS_END));   // 490..491

    assign sync = '{hsync: hs_n, vsync: vs_n, blank_n: active};

    // each stored pixel fills a 2x2 block on screen
    assign row_base = fb_addr_t'(v_cnt[9:1]) * fb_addr_t'(`FB_W);
    assign col      = fb_addr_t'(h_cnt[9:1]);

    // parked at word 0 during blanking
    assign rd_addr = active ? (row_base + col) : '0;

endmodule

`default_nettype wire

// ==== rtl/frame_buffer.sv ====
/* two-bank frame buffer */
`timescale 1ns/1ps
`default_nettype none
`include "cam_display_config.svh"

module frame_buffer (
    input  wire logic                       clk_25_vga,
    input  wire logic                       rst_n,
    input  wire cam_display_pkg::fb_write_t wr,
    input  wire cam_display_pkg::fb_addr_t  rd_addr,
    output cam_display_pkg::rgb565_t        rd_data
);
    import cam_display_pkg::*;

    localparam int BANK1_DEPTH = `FB_DEPTH - `FB_BANK0_DEPTH;   // 44032 words

    rgb565_t  bank0 [`FB_BANK0_DEPTH];
    rgb565_t  bank1 [BANK1_DEPTH];

    fb_addr_t wr_off;
    logic     wr_ok;
    fb_addr_t rd_off;
    fb_addr_t rd_addr_q;
    fb_addr_t rd_off_q;
    logic     rd_sel_q1;
    logic     rd_sel_q2;
    rgb565_t  bank0_q;
    rgb565_t  bank1_q;

    // bit 16 of the offset is the borrow, set for bank 0 addresses
    assign wr_off = wr.addr - fb_addr_t'(`FB_BANK0_DEPTH);
    assign rd_off = rd_addr - fb_addr_t'(`FB_BANK0_DEPTH);
    assign wr_ok  = wr.en && (wr.addr < fb_addr_t'(`FB_DEPTH));   // drop out of range

    always_ff @(posedge clk_25_vga) begin
        if (wr_ok && wr_off[16]) begin
            bank0[wr.addr[14:0]] <= wr.data;
        end
        if (wr_ok && !wr_off[16]) begin
            bank1[wr_off[15:0]] <= wr.data;
        end
    end

    // address stage, then array read stage
    always_ff @(posedge clk_25_vga) begin
        rd_addr_q <= rd_addr;
        rd_off_q  <= rd_off;
        bank0_q   <= bank0[rd_addr_q[14:0]];
        bank1_q   <= bank1[rd_off_q[15:0]];
    end

    // bank select follows the data through both stages
    always_ff @(posedge clk_25_vga or negedge rst_n) begin
        if (!rst_n) begin
            rd_sel_q1 <= 1'b0;
            rd_sel_q2 <= 1'b0;
        end else begin
            rd_sel_q1 <= !rd_off[16];
            rd_sel_q2 <= rd_sel_q1;
        end
    end

    assign rd_data = rd_sel_q2 ? bank1_q : bank0_q;

endmodule

`default_nettype wire

// ==== rtl/delay_line.sv ====
/* fixed delay line */
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
    parameter type      payload_t   = logic,
    parameter int       DEPTH       = 1,
    parameter payload_t RESET_VALUE = '0
) (
    input  wire logic     clk_25_vga,
    input  wire logic     rst_n,
    input  wire payload_t din,
    output payload_t      dout
);

    payload_t stage [DEPTH];   // stage 0 is nearest the input

    always_ff @(posedge clk_25_vga or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= RESET_VALUE;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

`default_nettype wire

// ==== rtl/pixel_convert.sv ====
/* rgb565 to rgb888 pixel stage */
`timescale 1ns/1ps
`default_nettype none

module pixel_convert (
    input  wire logic                     clk_25_vga,
    input  wire logic                     rst_n,
    input  wire cam_display_pkg::rgb565_t pix,
    input  wire logic                     active,
    input  wire logic                     gray_mode,
    output cam_display_pkg::rgb888_t      rgb
);
    import cam_display_pkg::*;

    rgb888_t     wide;
    logic [15:0] luma_sum;
    logic [7:0]  luma;
    rgb888_t     next_rgb;

    // low bits padded with ones
    assign wide = '{
        r: {pix.r, 3'b111},
        g: {pix.g, 2'b11},
        b: {pix.b, 3'b111}
    };

    // weights sum to 252, result scaled by 1/256
    assign luma_sum = 16'd76 * 16'(wide.r)
                    + 16'd150 * 16'(wide.g)
                    + 16'd26 * 16'(wide.b);
    assign luma = luma_sum[15:8];

    always_comb begin
        if (!active) begin
            next_rgb = '0;   // black in blanking
        end else if (gray_mode) begin
            next_rgb = '{r: luma, g: luma, b: luma};
        end else begin
            next_rgb = wide;
        end
    end

    always_ff @(posedge clk_25_vga or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= '0;
        end else begin
            rgb <= next_rgb;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cam_display_top.sv ====
/* frame buffer display top */
`timescale 1ns/1ps
`default_nettype none
`include "cam_display_config.svh"

module cam_display_top (
    input  wire logic                       clk_25_vga,
    input  wire logic                       rst_n,
    input  wire cam_display_pkg::fb_write_t fb_wr,
    input  wire logic                       gray_mode,
    output cam_display_pkg::vga_sync_t      vga_sync,
    output cam_display_pkg::rgb888_t        vga_rgb
);
    import cam_display_pkg::*;

    vga_sync_t sync_raw;
    logic      active_raw;
    fb_addr_t  rd_addr;
    rgb565_t   rd_data;
    logic      active_mem;   // lines up with rd_data

    vga_timing u_timing (
        .clk_25_vga (clk_25_vga),
        .rst_n      (rst_n),
        .sync       (sync_raw),
        .active     (active_raw),
        .rd_addr    (rd_addr)
    );

    frame_buffer u_fb (
        .clk_25_vga (clk_25_vga),
        .rst_n      (rst_n),
        .wr         (fb_wr),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    // active flag follows the memory read latency
    delay_line #(
        .payload_t   (logic),
        .DEPTH       (`MEM_RD_LAT),
        .RESET_VALUE (1'b0)
    ) u_active_dly (
        .clk_25_vga (clk_25_vga),
        .rst_n      (rst_n),
        .din        (active_raw),
        .dout       (active_mem)
    );

    // sync waits for memory plus pixel stage
    delay_line #(
        .payload_t   (vga_sync_t),
        .DEPTH       (`SYNC_DELAY),
        .RESET_VALUE (SYNC_IDLE)
    ) u_sync_dly (
        .clk_25_vga (clk_25_vga),
        .rst_n      (rst_n),
        .din        (sync_raw),
        .dout       (vga_sync)
    );

    pixel_convert u_pix (
        .clk_25_vga (clk_25_vga),
        .rst_n      (rst_n),
        .pix        (rd_data),
        .active     (active_mem),
        .gray_mode  (gray_mode),
        .rgb        (vga_rgb)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
/* testbench clock */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_25_vga
);

    initial begin
        clk_25_vga = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_25_vga = ~clk_25_vga;
        end
    end

endmodule

`default_nettype wire

// ==== verif/cam_display_assert.sv ====
/* vga output assertions */
`timescale 1ns/1ps
`default_nettype none

module cam_display_assert (
    input wire logic                       clk_25_vga,
    input wire logic                       rst_n,
    input wire cam_display_pkg::vga_sync_t vga_sync,
    input wire cam_display_pkg::rgb888_t   vga_rgb
);
    import cam_display_pkg::*;

    // black outside the picture
    blank_rgb_zero: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        !vga_sync.blank_n |-> (vga_rgb == '0))
        else $error("rgb is not zero while blank_n is low");

    // sync pulses stay out of the active area
    active_sync_idle: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
        vga_sync.blank_n |-> (vga_sync.hsync && vga_sync.vsync))
        else $error("sync pulse inside the active area");

endmodule

bind cam_display_top cam_display_assert u_out_assert (
    .clk_25_vga (clk_25_vga),
    .rst_n      (rst_n),
    .vga_sync   (vga_sync),
    .vga_rgb    (vga_rgb)
);

`default_nettype wire

// ==== verif/cam_display_tb.sv ====
/* camera display testbench */
`timescale 1ns/1ps
`default_nettype none
`include "cam_display_config.svh"

module cam_display_tb;
    import cam_display_pkg::*;

    localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
    localparam int TIMEOUT_CYCLES = 16 + `FB_DEPTH + 4 * FRAME_CYCLES + 10000;
    localparam int EDGE_LO        = `FB_BANK0_DEPTH - 1;   // last word of bank 0
    localparam int EDGE_HI        = `FB_BANK0_DEPTH;

    logic        clk_25_vga;
    logic        rst_n;
    fb_write_t   fb_wr;
    logic        gray_mode;
    vga_sync_t   vga_sync;
    rgb888_t     vga_rgb;

    logic [31:0] lcg_state = 32'h4818e74a;
    rgb565_t     model [`FB_DEPTH];
    int          errors = 0;
    int          cyc = 0;
    int          vs_fall_cyc = 0;

    tb_clock_gen #(.PERIOD_NS(8)) u_clk (.clk_25_vga(clk_25_vga));

    cam_display_top DUT (
        .clk_25_vga (clk_25_vga),
        .rst_n      (rst_n),
        .fb_wr      (fb_wr),
        .gray_mode  (gray_mode),
        .vga_sync   (vga_sync),
        .vga_rgb    (vga_rgb)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic rgb888_t expand(input rgb565_t p);
        rgb888_t w;
        w.r = {p.r, 3'b111};
        w.g = {p.g, 2'b11};
        w.b = {p.b, 3'b111};
        return w;
    endfunction

    function automatic rgb888_t to_gray(input rgb888_t c);
        int         sum;
        logic [7:0] lum;
        sum = 76 * int'(c.r) + 150 * int'(c.g) + 26 * int'(c.b);
        lum = 8'(sum >> 8);
        return '{r: lum, g: lum, b: lum};
    endfunction

    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act) else begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // idle output: hsync 1, vsync 1, blank_n 0, black
    task automatic check_reset_state(input string name);
        check_value({name, "_sync"}, 6, int'(vga_sync));
        check_value({name, "_rgb"}, 0, int'(vga_rgb));
    endtask

    task automatic fill_buffer();
        rgb565_t word;
        for (int a = 0; a < `FB_DEPTH; a++) begin
            lcg_state = lcg_next(lcg_state);
            word = rgb565_t'(lcg_state[31:16]);
            if (a == EDGE_LO) word = 16'hf81f;   // distinct pair across the split
            if (a == EDGE_HI) word = 16'h07e0;
            model[a] = word;
            fb_wr.en = 1'b1;
            fb_wr.addr = fb_addr_t'(a);
            fb_wr.data = word;
            @(negedge clk_25_vga);
        end
        fb_wr = '0;
    endtask

    task automatic wait_vsync_fall();
        logic prev;
        prev = vga_sync.vsync;
        @(negedge clk_25_vga);
        while (!(prev && !vga_sync.vsync)) begin
            prev = vga_sync.vsync;
            @(negedge clk_25_vga);
        end
        vs_fall_cyc = cyc;
    endtask

    task automatic wait_active();
        while (!vga_sync.blank_n) @(negedge clk_25_vga);
    endtask

    // runs from the first active pixel up to the next vsync fall
    task automatic scan_frame(input bit gray);
        int        x;
        int        y;
        int        hs_fall;
        int        addr;
        bit        done;
        string     name;
        rgb888_t   exp;
        vga_sync_t prev;
        x = 0;
        y = 0;
        hs_fall = -1;
        done = 1'b0;
        prev = vga_sync;
        while (!done) begin
            if (vga_sync.blank_n) begin
                addr = (y / 2) * `FB_W + x / 2;
                exp = expand(model[addr]);
                if (gray) exp = to_gray(exp);
                if (addr == EDGE_LO || addr == EDGE_HI) name = "bank_boundary";
                else name = gray ? "gray_pixel" : "color_pixel";
                check_value(name, int'(exp), int'(vga_rgb));
                x++;
            end else begin
                check_value("blank_rgb", 0, int'(vga_rgb));
                if (prev.blank_n) begin   // end of an active line
                    check_value("line_active", `H_ACTIVE, x);
                    x = 0;
                    y++;
                end
            end
            if (prev.hsync && !vga_sync.hsync) begin
                if (hs_fall >= 0) check_value("hsync_period", `H_TOTAL, cyc - hs_fall);
                hs_fall = cyc;
            end
            if (!prev.hsync && vga_sync.hsync && hs_fall >= 0) begin
                check_value("hsync_width", `H_SYNC, cyc - hs_fall);
            end
            if (prev.vsync && !vga_sync.vsync) begin
                check_value("frame_lines", `V_ACTIVE, y);
                check_value("vsync_period", FRAME_CYCLES, cyc - vs_fall_cyc);
                vs_fall_cyc = cyc;
                done = 1'b1;
            end else begin
                prev = vga_sync;
                @(negedge clk_25_vga);
            end
        end
    endtask

    always @(posedge clk_25_vga) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: no result after %0d cycles", cyc);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        fb_wr = '0;
        gray_mode = 1'b0;
        repeat (16) begin
            @(negedge clk_25_vga);
            check_reset_state("reset");
        end
        rst_n = 1'b1;
        @(negedge clk_25_vga);
        check_reset_state("after_reset");
        fill_buffer();
        wait_vsync_fall();
        wait_active();
        scan_frame(1'b0);
        gray_mode = 1'b1;   // vsync low at this point
        wait_active();
        scan_frame(1'b1);
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/cam_display_pkg.sv
rtl/vga_timing.sv
rtl/frame_buffer.sv
rtl/delay_line.sv
rtl/pixel_convert.sv
rtl/cam_display_top.sv
verif/tb_clock_gen.sv
verif/cam_display_assert.sv
verif/cam_display_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the display testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module cam_display_tb -o cam_display_sim || exit 1
./obj_dir/cam_display_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "RESULT: PASS" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
